//--- common/cpu_pkg.sv
/*
 * shared definitions for the 16-bit multi-cycle core
 * holds the address map, widths, opcodes, fsm states and the instruction word
 * design units pull it in with a wildcard import in their header
 */
package cpu_pkg;

	// ----------------------------------------
	// widths and sizes
	// ----------------------------------------
	localparam int word_w     = 16;
	// pc and data address are word indices
	localparam int pc_w       = 11;
	localparam int reg_count  = 16;
	// one instruction cache line
	localparam int line_words = 128;
	localparam int idx_w      = $clog2(line_words);
	// pc bits above the line index
	localparam int tag_w      = pc_w - idx_w;
	localparam int addr_w     = 32;

	// byte base of instruction and data memory
	// byte address = mem_base + 2 * word index
	localparam logic [addr_w-1:0] mem_base = 32'h0000_1000;

	// ----------------------------------------
	// opcodes
	// ----------------------------------------
	// func 0 add, func 1 sub
	localparam logic [2:0] op_arith = 3'd0;
	// func 0 slt, func 1 mult
	localparam logic [2:0] op_cmp   = 3'd1;
	localparam logic [2:0] op_load  = 3'd2;
	localparam logic [2:0] op_store = 3'd3;
	localparam logic [2:0] op_beq   = 3'd4;
	localparam logic [2:0] op_jump  = 3'd5;

	// core fsm
	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_decode,
		st_execute,
		st_mem_wait,
		st_write_back
	} core_state_t;

	// one fetched word, three views of it
	typedef union packed {
		struct packed {
			logic [2:0] opcode;
			logic [3:0] rs;
			logic [3:0] rt;
			logic [3:0] rd;
			logic       func;
		} r_fmt;
		struct packed {
			logic [2:0]        opcode;
			logic [3:0]        rs;
			logic [3:0]        rt;
			logic signed [4:0] imm;
		} i_fmt;
		struct packed {
			logic [2:0]      opcode;
			logic            pad_hi;
			logic [pc_w-1:0] target;
			logic            pad_lo;
		} j_fmt;
	} instr_t;

endpackage

//--- common/fetch_if.sv
/*
 * instruction fetch bus between the execution core and the instruction cache
 * four-phase req/ack, pc held while req is high, instr valid while ack is high
 */
`timescale 1ns/1ps

interface fetch_if import cpu_pkg::*; ();

	// core side
	logic            req;
	logic [pc_w-1:0] pc;

	// cache side
	logic            ack;
	instr_t          instr;

	modport core (output req, output pc, input ack, input instr);

	modport cache (input req, input pc, output ack, output instr);

endinterface

//--- common/mem_if.sv
/*
 * data access bus between the execution core and the load/store bus master
 * four-phase req/ack, one load or one store per handshake
 * on a load rdata is valid while ack is high
 */
`timescale 1ns/1ps

interface mem_if import cpu_pkg::*; ();

	// request, held stable until ack
	logic              req;
	logic              write;
	logic [pc_w-1:0]   addr;
	logic [word_w-1:0] wdata;

	// completion
	logic              ack;
	logic [word_w-1:0] rdata;

	modport core (
		output req, output write, output addr, output wdata,
		input ack, input rdata
	);

	modport port (
		input req, input write, input addr, input wdata,
		output ack, output rdata
	);

endinterface

//--- fetch/inst_cache.sv
/*
 * direct-mapped instruction cache, a single 128-word line with one tag
 * hit answers two cycles after req, a miss refills the whole line
 * over the burst read port before it is served as a hit
 */
`timescale 1ns/1ps

module inst_cache import cpu_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	fetch_if.cache            fetch,
	output logic [addr_w-1:0] inst_araddr,
	output logic              inst_arvalid,
	input  logic              inst_arready,
	input  logic [word_w-1:0] inst_rdata,
	input  logic              inst_rvalid,
	input  logic              inst_rlast,
	output logic              inst_rready
);

	// line storage, plain array
	logic [word_w-1:0] line_mem [line_words];

	logic [tag_w-1:0]  tag;
	logic              valid;
	logic              ack_q;
	// array read in flight
	logic              rd_pend;
	logic [idx_w-1:0]  rd_idx;
	// running refill index
	logic [idx_w-1:0]  wr_idx;
	logic [word_w-1:0] instr_q;

	logic hit;
	logic start;
	logic ar_fire;
	logic r_fire;

	// ----------------------------------------
	// lookup
	// ----------------------------------------
	assign hit = valid && (tag == fetch.pc[pc_w-1:idx_w]);

	// new lookup only when nothing is pending for this request
	assign start = fetch.req && !ack_q && !rd_pend && !inst_arvalid && !inst_rready;

	assign ar_fire = inst_arvalid && inst_arready;
	assign r_fire  = inst_rvalid && inst_rready;

	// line base: tag bits above a zero word index and the byte bit
	assign inst_araddr = mem_base + addr_w'({fetch.pc[pc_w-1:idx_w], {(idx_w + 1){1'b0}}});

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag          <= '0;
			valid        <= 1'b0;
			ack_q        <= 1'b0;
			rd_pend      <= 1'b0;
			inst_arvalid <= 1'b0;
			inst_rready  <= 1'b0;
			wr_idx       <= '0;
		end else begin
			// ack held until the core releases req
			if (!fetch.req)
				ack_q <= 1'b0;
			else if (rd_pend)
				ack_q <= 1'b1;

			// hit: tag compare now, array read next cycle
			rd_pend <= start && hit;

			// miss: one burst for the whole line
			if (start && !hit)
				inst_arvalid <= 1'b1;
			else if (ar_fire)
				inst_arvalid <= 1'b0;

			if (ar_fire)
				inst_rready <= 1'b1;
			else if (r_fire && inst_rlast)
				inst_rready <= 1'b0;

			if (r_fire)
				wr_idx <= inst_rlast ? '0 : wr_idx + 1'b1;

			// line complete, the pending request retries as a hit
			if (r_fire && inst_rlast) begin
				tag   <= fetch.pc[pc_w-1:idx_w];
				valid <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// line array
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (r_fire)
			line_mem[wr_idx] <= inst_rdata;
		if (start)
			rd_idx <= fetch.pc[idx_w-1:0];
		if (rd_pend)
			instr_q <= line_mem[rd_idx];
	end

	// ack falls together with req
	assign fetch.ack   = ack_q && fetch.req;
	assign fetch.instr = instr_q;

	// burst address held until the memory takes it
	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		inst_arvalid && !inst_arready |=> inst_arvalid && $stable(inst_araddr));

	// memory marks the end of the line on beat 128
	line_len: assert property (@(posedge clk) disable iff (!rst_n)
		r_fire |-> (inst_rlast == (wr_idx == idx_w'(line_words - 1))));

endmodule

//--- verilog/data_port.sv
/*
 * load/store bus master for the core
 * each request becomes one single-beat read or one single-beat write
 * at mem_base plus twice the word address
 */
`timescale 1ns/1ps

module data_port import cpu_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	mem_if.port               mem,
	output logic [addr_w-1:0] data_araddr,
	output logic              data_arvalid,
	input  logic              data_arready,
	input  logic [word_w-1:0] data_rdata,
	input  logic              data_rvalid,
	output logic              data_rready,
	output logic [addr_w-1:0] awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [word_w-1:0] wdata,
	output logic              wvalid,
	input  logic              wready,
	input  logic              bvalid,
	output logic              bready
);

	logic [addr_w-1:0] byte_addr;
	logic              ack_q;
	// store channels finish independently
	logic              aw_done;
	logic              w_done;
	logic              busy;
	logic              start;
	logic [word_w-1:0] rdata_q;

	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign ar_fire = data_arvalid && data_arready;
	assign r_fire  = data_rvalid && data_rready;
	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	assign b_fire  = bvalid && bready;

	// core holds addr and wdata for the whole handshake
	assign byte_addr   = mem_base + addr_w'({mem.addr, 1'b0});
	assign data_araddr = byte_addr;
	assign awaddr      = byte_addr;
	assign wdata       = mem.wdata;

	assign busy  = data_arvalid || data_rready || awvalid || wvalid || aw_done || w_done || bready;
	assign start = mem.req && !ack_q && !busy;

	// ----------------------------------------
	// channel control
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q        <= 1'b0;
			data_arvalid <= 1'b0;
			data_rready  <= 1'b0;
			awvalid      <= 1'b0;
			wvalid       <= 1'b0;
			aw_done      <= 1'b0;
			w_done       <= 1'b0;
			bready       <= 1'b0;
		end else begin
			if (!mem.req)
				ack_q <= 1'b0;
			else if (r_fire || b_fire)
				ack_q <= 1'b1;

			// load: address, then one data beat
			if (start && !mem.write)
				data_arvalid <= 1'b1;
			else if (ar_fire)
				data_arvalid <= 1'b0;
			if (ar_fire)
				data_rready <= 1'b1;
			else if (r_fire)
				data_rready <= 1'b0;

			// store: address and data together, each drops on its own transfer
			if (start && mem.write) begin
				awvalid <= 1'b1;
				wvalid  <= 1'b1;
			end else begin
				if (aw_fire)
					awvalid <= 1'b0;
				if (w_fire)
					wvalid <= 1'b0;
			end
			if (aw_fire)
				aw_done <= 1'b1;
			if (w_fire)
				w_done <= 1'b1;

			// both sides through, wait for the response
			if (aw_done && w_done) begin
				bready  <= 1'b1;
				aw_done <= 1'b0;
				w_done  <= 1'b0;
			end else if (b_fire) begin
				bready <= 1'b0;
			end
		end
	end

	// read beat kept for the core
	always_ff @(posedge clk) begin
		if (r_fire)
			rdata_q <= data_rdata;
	end

	assign mem.ack   = ack_q && mem.req;
	assign mem.rdata = rdata_q;

	// write data held until the memory takes it
	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

//--- core/exec_core.sv
/*
 * execution core, one instruction at a time
 * fetch, decode, execute, optional memory wait and write back
 * io_stall drops for one cycle after each retired instruction
 */
`timescale 1ns/1ps

module exec_core import cpu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	output logic  io_stall,
	fetch_if.core fetch,
	mem_if.core   mem
);

	core_state_t state;
	logic [pc_w-1:0] pc;
	logic [pc_w-1:0] next_pc;

	// architectural registers
	logic signed [word_w-1:0] regs [reg_count];

	// current instruction and latched operands
	instr_t                   ir;
	logic signed [word_w-1:0] rs_val;
	logic signed [word_w-1:0] rt_val;
	logic signed [word_w-1:0] alu_res;
	// alu result or loaded word
	logic [word_w-1:0]        wb_val;
	logic [pc_w-1:0]          data_addr;
	logic [3:0]               wb_idx;
	logic                     is_load;

	logic fetch_req;
	logic mem_req;
	logic mem_write;

	assign is_load = (ir.i_fmt.opcode == op_load);
	// load writes rt, arithmetic writes rd
	assign wb_idx  = is_load ? ir.i_fmt.rt : ir.r_fmt.rd;

	// ----------------------------------------
	// alu and next pc
	// ----------------------------------------
	always_comb begin
		case (ir.r_fmt.opcode)
			op_arith: alu_res = ir.r_fmt.func ? rs_val - rt_val : rs_val + rt_val;
			// mult keeps the low half
			op_cmp:   alu_res = ir.r_fmt.func ? rs_val * rt_val : word_w'(rs_val < rt_val);
			default:  alu_res = '0;
		endcase
	end

	always_comb begin
		next_pc = pc + 1'b1;
		if (ir.j_fmt.opcode == op_jump)
			next_pc = ir.j_fmt.target;
		else if (ir.i_fmt.opcode == op_beq && rs_val == rt_val)
			next_pc = pc + 1'b1 + pc_w'(ir.i_fmt.imm);
	end

	// ----------------------------------------
	// fsm and handshakes
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			pc        <= '0;
			fetch_req <= 1'b0;
			mem_req   <= 1'b0;
			mem_write <= 1'b0;
			io_stall  <= 1'b1;
		end else begin
			io_stall <= 1'b1;
			case (state)
				st_idle: begin
					state     <= st_fetch;
					fetch_req <= 1'b1;
				end
				// leave once ack has fallen again
				st_fetch: begin
					if (fetch_req && fetch.ack)
						fetch_req <= 1'b0;
					else if (!fetch_req && !fetch.ack)
						state <= st_decode;
				end
				st_decode: state <= st_execute;
				st_execute: begin
					pc <= next_pc;
					case (ir.r_fmt.opcode)
						op_arith, op_cmp: state <= st_write_back;
						op_load, op_store: begin
							state     <= st_mem_wait;
							mem_req   <= 1'b1;
							mem_write <= (ir.r_fmt.opcode == op_store);
						end
						// beq, jump and unused codes retire here
						default: begin
							state     <= st_fetch;
							fetch_req <= 1'b1;
							io_stall  <= 1'b0;
						end
					endcase
				end
				st_mem_wait: begin
					if (mem_req && mem.ack) begin
						mem_req <= 1'b0;
					end else if (!mem_req && !mem.ack) begin
						if (mem_write) begin
							state     <= st_fetch;
							fetch_req <= 1'b1;
							io_stall  <= 1'b0;
						end else begin
							state <= st_write_back;
						end
					end
				end
				st_write_back: begin
					state     <= st_fetch;
					fetch_req <= 1'b1;
					io_stall  <= 1'b0;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clk) begin
		if (state == st_fetch && fetch_req && fetch.ack)
			ir <= fetch.instr;
		if (state == st_decode) begin
			rs_val <= regs[ir.r_fmt.rs];
			rt_val <= regs[ir.r_fmt.rt];
		end
		if (state == st_execute) begin
			wb_val    <= alu_res;
			// rs plus sign-extended imm, word index
			data_addr <= pc_w'(rs_val + word_w'(ir.i_fmt.imm));
		end
		if (state == st_mem_wait && mem_req && mem.ack && !mem_write)
			wb_val <= mem.rdata;
	end

	// register file
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (state == st_write_back) begin
			regs[wb_idx] <= wb_val;
		end
	end

	assign fetch.req = fetch_req;
	assign fetch.pc  = pc;
	assign mem.req   = mem_req;
	assign mem.write = mem_write;
	assign mem.addr  = data_addr;
	assign mem.wdata = rt_val;

	// four-phase rule, no new request before the previous ack is gone
	fetch_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(fetch.req) |-> !fetch.ack);
	mem_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem.req) |-> !mem.ack);

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {st_idle, st_fetch, st_decode, st_execute, st_mem_wait, st_write_back});

endmodule

//--- verilog/cpu_top.sv
/*
 * top level of the 16-bit core
 * joins the execution core, the instruction cache and the data bus master
 * and brings out the instruction, data read and write ports
 */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	output logic              io_stall,
	// instruction read port, burst
	output logic [addr_w-1:0] inst_araddr,
	output logic              inst_arvalid,
	input  logic              inst_arready,
	input  logic [word_w-1:0] inst_rdata,
	input  logic              inst_rvalid,
	input  logic              inst_rlast,
	output logic              inst_rready,
	// data read port, single beat
	output logic [addr_w-1:0] data_araddr,
	output logic              data_arvalid,
	input  logic              data_arready,
	input  logic [word_w-1:0] data_rdata,
	input  logic              data_rvalid,
	output logic              data_rready,
	// write port
	output logic [addr_w-1:0] awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [word_w-1:0] wdata,
	output logic              wvalid,
	input  logic              wready,
	input  logic              bvalid,
	output logic              bready
);

	// ----------------------------------------
	// internal buses
	// ----------------------------------------
	fetch_if fetch_bus ();
	mem_if   mem_bus ();

	exec_core u_core (
		.fetch (fetch_bus.core),
		.mem   (mem_bus.core),
		.*
	);

	// instruction side master
	inst_cache u_icache (
		.fetch (fetch_bus.cache),
		.*
	);

	// data side master
	data_port u_dport (
		.mem (mem_bus.port),
		.*
	);

endmodule

//--- testbench/tb_dram.sv
/*
 * slave models for the instruction and data memories of the core
 * word-indexed arrays loaded by the testbench, random 0 to 3 cycle
 * delays on every ready and valid, outputs driven 2 ns after the clock edge
 */
`timescale 1ns/1ps

module tb_dram import cpu_pkg::*; (
	input  logic              clk,
	input  logic [addr_w-1:0] inst_araddr,
	input  logic              inst_arvalid,
	output logic              inst_arready,
	output logic [word_w-1:0] inst_rdata,
	output logic              inst_rvalid,
	output logic              inst_rlast,
	input  logic              inst_rready,
	input  logic [addr_w-1:0] data_araddr,
	input  logic              data_arvalid,
	output logic              data_arready,
	output logic [word_w-1:0] data_rdata,
	output logic              data_rvalid,
	input  logic              data_rready,
	input  logic [addr_w-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  logic [word_w-1:0] wdata,
	input  logic              wvalid,
	output logic              wready,
	output logic              bvalid,
	input  logic              bready
);

	// word-indexed memories
	logic [word_w-1:0] imem [1 << pc_w];
	logic [word_w-1:0] dmem [1 << pc_w];

	// transfers seen at the falling edge, acted on after the next rising edge
	logic iar_fire, ir_fire, dar_fire, dr_fire, aw_fire, w_fire, b_fire;
	logic [pc_w-1:0]   iar_word;
	logic [pc_w-1:0]   dar_word;
	logic [pc_w-1:0]   rd_word;
	logic [pc_w-1:0]   st_word;
	logic [word_w-1:0] st_data;

	// burst in progress
	logic [pc_w-1:0] beat_word;
	int              beats_left;
	logic            rd_pend;
	logic            aw_seen;
	logic            w_seen;

	// cycles left before the next ready or valid
	int iar_gap, ir_gap, dar_gap, dr_gap, aw_gap, w_gap, b_gap;

	function automatic int pick_delay();
		return int'($urandom_range(3, 0));
	endfunction

	function automatic logic [pc_w-1:0] word_of(input logic [addr_w-1:0] addr);
		return pc_w'((addr - mem_base) >> 1);
	endfunction

	initial begin
		inst_arready = 1'b0;
		inst_rdata   = '0;
		inst_rvalid  = 1'b0;
		inst_rlast   = 1'b0;
		data_arready = 1'b0;
		data_rdata   = '0;
		data_rvalid  = 1'b0;
		awready      = 1'b0;
		wready       = 1'b0;
		bvalid       = 1'b0;
		beats_left   = 0;
		rd_pend      = 1'b0;
		aw_seen      = 1'b0;
		w_seen       = 1'b0;
		iar_gap      = 0;
		ir_gap       = 0;
		dar_gap      = 0;
		dr_gap       = 0;
		aw_gap       = 0;
		w_gap        = 0;
		b_gap        = 0;
	end

	// ----------------------------------------
	// sample handshakes mid-cycle
	// ----------------------------------------
	always @(negedge clk) begin
		iar_fire = inst_arvalid && inst_arready;
		ir_fire  = inst_rvalid && inst_rready;
		dar_fire = data_arvalid && data_arready;
		dr_fire  = data_rvalid && data_rready;
		aw_fire  = awvalid && awready;
		w_fire   = wvalid && wready;
		b_fire   = bvalid && bready;
		iar_word = word_of(inst_araddr);
		dar_word = word_of(data_araddr);
		if (aw_fire)
			st_word = word_of(awaddr);
		if (w_fire)
			st_data = wdata;
	end

	always @(posedge clk) begin
		#2;
		// instruction address, starts a 128-beat line burst
		if (iar_fire) begin
			inst_arready = 1'b0;
			beat_word    = iar_word;
			beats_left   = line_words;
			iar_gap      = pick_delay();
			ir_gap       = pick_delay();
		end else if (inst_arvalid && !inst_arready) begin
			if (iar_gap == 0)
				inst_arready = 1'b1;
			else
				iar_gap--;
		end

		// burst beats in address order, last one flagged
		if (ir_fire) begin
			inst_rvalid = 1'b0;
			inst_rlast  = 1'b0;
			beat_word   = beat_word + 1'b1;
			beats_left  = beats_left - 1;
			ir_gap      = pick_delay();
		end
		if (beats_left > 0 && !inst_rvalid) begin
			if (ir_gap == 0) begin
				inst_rvalid = 1'b1;
				inst_rdata  = imem[beat_word];
				inst_rlast  = (beats_left == 1);
			end else begin
				ir_gap--;
			end
		end

		// ----------------------------------------
		// single-beat data read
		// ----------------------------------------
		if (dar_fire) begin
			data_arready = 1'b0;
			rd_word      = dar_word;
			rd_pend      = 1'b1;
			dar_gap      = pick_delay();
			dr_gap       = pick_delay();
		end else if (data_arvalid && !data_arready) begin
			if (dar_gap == 0)
				data_arready = 1'b1;
			else
				dar_gap--;
		end
		if (dr_fire)
			data_rvalid = 1'b0;
		if (rd_pend && !data_rvalid) begin
			if (dr_gap == 0) begin
				data_rvalid = 1'b1;
				data_rdata  = dmem[rd_word];
				rd_pend     = 1'b0;
			end else begin
				dr_gap--;
			end
		end

		// ----------------------------------------
		// write, address and data independent
		// ----------------------------------------
		if (aw_fire) begin
			awready = 1'b0;
			aw_seen = 1'b1;
			aw_gap  = pick_delay();
		end else if (awvalid && !awready) begin
			if (aw_gap == 0)
				awready = 1'b1;
			else
				aw_gap--;
		end
		if (w_fire) begin
			wready = 1'b0;
			w_seen = 1'b1;
			w_gap  = pick_delay();
		end else if (wvalid && !wready) begin
			if (w_gap == 0)
				wready = 1'b1;
			else
				w_gap--;
		end
		if (b_fire) begin
			bvalid = 1'b0;
			b_gap  = pick_delay();
		end
		// memory updated when the response goes out
		if (aw_seen && w_seen && !bvalid) begin
			if (b_gap == 0) begin
				dmem[st_word] = st_data;
				bvalid        = 1'b1;
				aw_seen       = 1'b0;
				w_seen        = 1'b0;
			end else begin
				b_gap--;
			end
		end
	end

endmodule

//--- testbench/cpu_tb.sv
/*
 * testbench for the 16-bit core
 * loads a small program, runs an architectural model one instruction
 * ahead of the core, and checks stores, bursts, retire pulses and valid hold
 */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	localparam int timeout_cycles = 20000;

	logic              clk;
	logic              rst_n;
	logic              io_stall;
	logic [addr_w-1:0] inst_araddr;
	logic              inst_arvalid;
	logic              inst_arready;
	logic [word_w-1:0] inst_rdata;
	logic              inst_rvalid;
	logic              inst_rlast;
	logic              inst_rready;
	logic [addr_w-1:0] data_araddr;
	logic              data_arvalid;
	logic              data_arready;
	logic [word_w-1:0] data_rdata;
	logic              data_rvalid;
	logic              data_rready;
	logic [addr_w-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [word_w-1:0] wdata;
	logic              wvalid;
	logic              wready;
	logic              bvalid;
	logic              bready;

	// architectural model
	logic [word_w-1:0] prog [1 << pc_w];
	logic [word_w-1:0] ref_dmem [1 << pc_w];
	logic [word_w-1:0] ref_regs [reg_count];
	logic [pc_w-1:0]   ref_pc;
	logic [tag_w-1:0]  ref_tag;
	logic              ref_line_ok;
	logic              ref_halted;
	int                ref_steps;
	int                ref_loads;
	int                ref_stores;
	int                pulses;

	// data beats and write responses seen on the bus
	int                rd_beats;
	int                b_resps;

	// expected and observed bus traffic
	logic [addr_w-1:0] exp_st_addr [$];
	logic [word_w-1:0] exp_st_data [$];
	logic [addr_w-1:0] exp_burst [$];
	logic [addr_w-1:0] got_aw [$];
	logic [word_w-1:0] got_w [$];

	// previous sample of each master valid, ready and payload
	logic              stall_q;
	logic              p_iar_v, p_iar_r, p_dar_v, p_dar_r, p_aw_v, p_aw_r, p_w_v, p_w_r;
	logic [addr_w-1:0] p_iar_a;
	logic [addr_w-1:0] p_dar_a;
	logic [addr_w-1:0] p_aw_a;
	logic [word_w-1:0] p_w_d;

	cpu_top dut_i (.*);

	tb_dram mem_i (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// instruction encoders
	function automatic logic [word_w-1:0] rtype(input logic [2:0] op, input int rs,
		input int rt, input int rd, input logic func);
		return {op, 4'(rs), 4'(rt), 4'(rd), func};
	endfunction

	function automatic logic [word_w-1:0] itype(input logic [2:0] op, input int rs,
		input int rt, input int imm);
		return {op, 4'(rs), 4'(rt), 5'(imm)};
	endfunction

	function automatic logic [word_w-1:0] jump_to(input int target);
		return {op_jump, 1'b0, 11'(target), 1'b0};
	endfunction

	// ----------------------------------------
	// reference model, one instruction per call
	// ----------------------------------------
	function automatic void step_model();
		logic [word_w-1:0] ins;
		logic [2:0]        op;
		logic [3:0]        rs;
		logic [3:0]        rt;
		logic [3:0]        rd;
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] imm_x;
		logic [pc_w-1:0]   ea;
		logic [pc_w-1:0]   nxt;

		ins = prog[ref_pc];
		// single held line, any other line costs one burst
		if (!ref_line_ok || ref_tag != ref_pc[pc_w-1:pc_w-tag_w]) begin
			exp_burst.push_back(mem_base + addr_w'({ref_pc[pc_w-1:pc_w-tag_w], 8'h00}));
			ref_tag     = ref_pc[pc_w-1:pc_w-tag_w];
			ref_line_ok = 1'b1;
		end
		op    = ins[15:13];
		rs    = ins[12:9];
		rt    = ins[8:5];
		rd    = ins[4:1];
		a     = ref_regs[rs];
		b     = ref_regs[rt];
		imm_x = {{11{ins[4]}}, ins[4:0]};
		ea    = pc_w'(a + imm_x);
		nxt   = ref_pc + 1'b1;
		case (op)
			op_arith: ref_regs[rd] = ins[0] ? a - b : a + b;
			// mult keeps the low half, slt is signed
			op_cmp:   ref_regs[rd] = ins[0] ? a * b : {15'd0, $signed(a) < $signed(b)};
			op_load: begin
				ref_regs[rt] = ref_dmem[ea];
				ref_loads++;
			end
			op_store: begin
				ref_dmem[ea] = b;
				exp_st_addr.push_back(mem_base + addr_w'({ea, 1'b0}));
				exp_st_data.push_back(b);
				ref_stores++;
			end
			op_beq: begin
				if (a == b)
					nxt = pc_w'(ref_pc + pc_w'(1) + pc_w'(imm_x));
			end
			op_jump: begin
				nxt = ins[11:1];
				// jump to self is the final halt
				if (nxt == ref_pc)
					ref_halted = 1'b1;
			end
			default: ;
		endcase
		ref_pc = nxt;
		ref_steps++;
	endfunction

	task automatic load_program();
		int i;
		for (i = 0; i < (1 << pc_w); i++) begin
			// unused words halt where they stand
			prog[i]     = jump_to(i);
			ref_dmem[i] = word_w'(i * 16'h02b5 ^ 16'hc35a);
		end
		// loads, one with a negative offset that wraps to the top
		prog[0]   = itype(op_load, 0, 1, 1);
		prog[1]   = itype(op_load, 0, 2, 2);
		prog[2]   = itype(op_load, 0, 3, -3);
		prog[3]   = rtype(op_arith, 1, 2, 4, 1'b0);
		prog[4]   = rtype(op_arith, 1, 3, 5, 1'b1);
		prog[5]   = rtype(op_cmp, 1, 3, 6, 1'b0);
		prog[6]   = rtype(op_cmp, 3, 1, 7, 1'b0);
		prog[7]   = rtype(op_cmp, 2, 3, 8, 1'b1);
		for (i = 0; i < 5; i++)
			prog[8 + i] = itype(op_store, 0, 4 + i, 8 + i);
		// loaded value to fresh addresses
		prog[13]  = itype(op_store, 0, 3, 13);
		prog[14]  = itype(op_store, 0, 1, -6);
		// taken beq skips two stores, untaken one falls through
		prog[15]  = itype(op_beq, 1, 1, 2);
		prog[16]  = itype(op_store, 0, 2, 14);
		prog[17]  = itype(op_store, 0, 2, 15);
		prog[18]  = itype(op_beq, 1, 2, 3);
		prog[19]  = itype(op_store, 0, 2, 14);
		// over to line 1 and back
		prog[20]  = jump_to(200);
		prog[21]  = itype(op_store, 0, 3, 15);
		prog[200] = rtype(op_arith, 4, 5, 10, 1'b0);
		prog[201] = itype(op_store, 0, 10, 15);
		prog[202] = jump_to(22);
		// inside the held line, no burst
		prog[22]  = jump_to(25);
		prog[23]  = itype(op_store, 0, 2, 3);
		prog[25]  = itype(op_store, 0, 6, 4);
		prog[26]  = jump_to(26);
		for (i = 0; i < (1 << pc_w); i++) begin
			mem_i.imem[i] = prog[i];
			mem_i.dmem[i] = ref_dmem[i];
		end
		for (i = 0; i < reg_count; i++)
			ref_regs[i] = '0;
		ref_pc      = '0;
		ref_tag     = '0;
		ref_line_ok = 1'b0;
		ref_halted  = 1'b0;
		ref_steps   = 0;
		ref_loads   = 0;
		ref_stores  = 0;
	endtask

	// ----------------------------------------
	// compare process, mid-cycle sampling
	// ----------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (!io_stall) begin
				check("io_stall pulse width", 1, stall_q);
				// the retiring instruction and all before it are done on the bus
				check("loads before retire", ref_loads, rd_beats);
				check("stores before retire", ref_stores, b_resps);
				pulses++;
				if (!ref_halted)
					step_model();
			end
			stall_q = io_stall;

			if (data_rvalid && data_rready)
				rd_beats++;
			if (bvalid && bready)
				b_resps++;

			// pair address and data of each store
			if (awvalid && awready)
				got_aw.push_back(awaddr);
			if (wvalid && wready)
				got_w.push_back(wdata);
			if (got_aw.size() != 0 && got_w.size() != 0) begin
				if (exp_st_addr.size() == 0) begin
					$display("a store appeared that the program never makes");
					$display("Testbench failed");
					$fatal(1);
				end else begin
					check("store address", exp_st_addr.pop_front(), got_aw.pop_front());
					check("store data", exp_st_data.pop_front(), got_w.pop_front());
				end
			end

			if (inst_arvalid && inst_arready) begin
				if (exp_burst.size() == 0) begin
					$display("an instruction burst started for a line already held");
					$display("Testbench failed");
					$fatal(1);
				end else begin
					check("burst address", exp_burst.pop_front(), inst_araddr);
				end
			end

			// a waiting valid keeps itself and its payload
			if (p_iar_v && !p_iar_r) begin
				check("inst_arvalid held", 1, inst_arvalid);
				check("inst_araddr stable", p_iar_a, inst_araddr);
			end
			if (p_dar_v && !p_dar_r) begin
				check("data_arvalid held", 1, data_arvalid);
				check("data_araddr stable", p_dar_a, data_araddr);
			end
			if (p_aw_v && !p_aw_r) begin
				check("awvalid held", 1, awvalid);
				check("awaddr stable", p_aw_a, awaddr);
			end
			if (p_w_v && !p_w_r) begin
				check("wvalid held", 1, wvalid);
				check("wdata stable", p_w_d, wdata);
			end
			p_iar_v = inst_arvalid;
			p_iar_r = inst_arready;
			p_iar_a = inst_araddr;
			p_dar_v = data_arvalid;
			p_dar_r = data_arready;
			p_dar_a = data_araddr;
			p_aw_v  = awvalid;
			p_aw_r  = awready;
			p_aw_a  = awaddr;
			p_w_v   = wvalid;
			p_w_r   = wready;
			p_w_d   = wdata;
		end
	end

	initial begin
		int cycles;
		void'($urandom(32'h8298f908));
		rst_n    = 1'b0;
		stall_q  = 1'b1;
		pulses   = 0;
		rd_beats = 0;
		b_resps  = 0;
		p_iar_v  = 1'b0;
		p_dar_v  = 1'b0;
		p_aw_v   = 1'b0;
		p_w_v    = 1'b0;
		load_program();
		// model leads the core by one instruction
		step_model();
		repeat (4) @(posedge clk);
		#2 rst_n = 1'b1;
		cycles = 0;
		while (!(ref_halted && pulses == ref_steps)) begin
			@(posedge clk);
			cycles++;
			if (cycles > timeout_cycles) begin
				$display("timeout, the program never retired its final halt");
				$display("Testbench failed");
				$fatal(1);
			end
		end
		if (exp_st_addr.size() != 0 || exp_burst.size() != 0 || got_aw.size() != 0
			|| got_w.size() != 0) begin
			$display("stores or bursts expected by the model never completed on the bus");
			$display("Testbench failed");
			$fatal(1);
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

//--- src.f
common/cpu_pkg.sv
common/fetch_if.sv
common/mem_if.sv
fetch/inst_cache.sv
verilog/data_port.sv
core/exec_core.sv
verilog/cpu_top.sv
testbench/tb_dram.sv
testbench/cpu_tb.sv

//--- Makefile
# Verilator build and run for the 16-bit core testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
